// ==== build.f ====
+incdir+.
mac_frame_pkg.sv
frame_byte_source.sv
fcs_inserter.sv
word_packer.sv
mac_frame_gen.sv
mac_frame_gen_asserts.sv
tb_mac_frame_gen.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the testbench with verilator, pass only on the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_mac_frame_gen -o sim_tb || exit 1

out=$(./obj_dir/sim_tb +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "No errors" && exit 0 || exit 1

// ==== tb_mac_frame_gen.sv ====
`include "mac_frame_params.svh"

module tb_mac_frame_gen;
    timeunit 1ns;
    timeprecision 1ps;
    import mac_frame_pkg::*;

    localparam int NUM_FRAMES  = 6;
    localparam int FRAME_WORDS = 9;
    localparam int MAX_CYCLES  = NUM_FRAMES * 150 + 100;  // ~70 cycles per frame plus gaps

    logic        clk = 1'b0;
    logic        i_rst_n;
    logic        i_start;
    frame_req_t  i_req;
    payload_t    i_payload;
    logic        o_valid;
    logic [63:0] o_word;
    logic        o_last;

    logic [31:0] lfsr_q = 32'hdb8c_8cb1;
    logic [64:0] exp_q[$];       // {last, word}
    logic [64:0] exp_entry;
    int          error_count   = 0;
    int          words_checked = 0;
    int          cycle_count   = 0;

    mac_frame_gen mac_frame_gen_inst (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_start   (i_start),
        .i_req     (i_req),
        .i_payload (i_payload),
        .o_valid   (o_valid),
        .o_word    (o_word),
        .o_last    (o_last)
    );

    always #10 clk = ~clk;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[62:0], lfsr_q[0]};
        end
    endtask

    task automatic random_request(input payload_mode_e mode, input logic [3:0] len,
                                  output frame_req_t req, output payload_t pay);
        logic [63:0] v;
        random_bits(48, v);
        req.dest = v[47:0];
        random_bits(48, v);
        req.src = v[47:0];
        random_bits(16, v);
        req.eth_type = v[15:0];
        random_bits(64, v);
        pay        = v;
        req.length = len;
        req.mode   = mode;
    endtask

    // reflected crc-32 taking each byte lsb first
    function automatic logic [31:0] crc_next(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) c = (c >> 1) ^ (`MAC_CRC_POLY & {32{c[0] ^ b[i]}});
        return c;
    endfunction

    // 72 frame bytes grouped into nine words
    task automatic push_expected(input frame_req_t req, input payload_t pay);
        logic [7:0]  fb [0:71];
        logic [3:0]  len;
        logic [31:0] crc;
        logic [63:0] w;
        len = (req.length > 4'd8) ? 4'd8 : req.length;
        for (int i = 0; i < 7; i++) fb[i] = 8'h55;
        fb[7] = 8'hd5;                      // sfd
        for (int i = 0; i < 6; i++) begin
            fb[8 + i]  = req.dest[47 - 8*i -: 8];
            fb[14 + i] = req.src[47 - 8*i -: 8];
        end
        fb[20] = req.eth_type[15:8];
        fb[21] = req.eth_type[7:0];
        for (int i = 0; i < 46; i++) begin
            if (i >= len) begin
                fb[22 + i] = 8'h00;     // pad
            end else if (req.mode == PAY_PATTERN) begin
                fb[22 + i] = `MAC_PATTERN_BYTE;
            end else begin
                fb[22 + i] = pay[i];
            end
        end
        crc = `MAC_CRC_INIT;
        for (int i = 8; i < 68; i++) crc = crc_next(crc, fb[i]);
        crc = ~crc;
        for (int i = 0; i < 4; i++) fb[68 + i] = crc[8*i +: 8];
        for (int k = 0; k < FRAME_WORDS; k++) begin
            w = '0;
            for (int j = 0; j < 8; j++) w = {w[55:0], fb[8*k + j]};
            exp_q.push_back({k == FRAME_WORDS - 1, w});
        end
    endtask

    // called at a rising edge
    task automatic start_frame(input frame_req_t req, input payload_t pay, input logic honoured);
        i_start   <= 1'b1;
        i_req     <= req;
        i_payload <= pay;
        if (honoured) push_expected(req, pay);
        @(posedge clk);
        i_start <= 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);  // room for stray words
    endtask

    task automatic wait_source_last();
        do @(posedge clk);
        while (!(mac_frame_gen_inst.src_valid && mac_frame_gen_inst.src_beat.last));
    endtask

    task automatic finish_run();
        int assert_fails;
        assert_fails = mac_frame_gen_inst.mac_frame_gen_asserts_inst.fail_count;
        if (words_checked != NUM_FRAMES * FRAME_WORDS) begin
            $display("Error words_checked expected %h actual %h",
                     NUM_FRAMES * FRAME_WORDS, words_checked);
            error_count++;
        end
        $display("words checked %0d, errors %0d, assertion failures %0d",
                 words_checked, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        if (o_valid) begin
            if (exp_q.size() == 0) begin
                $display("Output word arrived while no frame was pending");
                error_count++;
            end else begin
                exp_entry = exp_q.pop_front();
                words_checked++;
                assert (o_word == exp_entry[63:0]) else begin
                    $display("Error o_word expected %h actual %h", exp_entry[63:0], o_word);
                    error_count++;
                end
                assert (o_last == exp_entry[64]) else begin
                    $display("Error o_last expected %h actual %h", exp_entry[64], o_last);
                    error_count++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count == MAX_CYCLES) begin
            $display("Timeout: the run did not complete within %0d cycles", MAX_CYCLES);
            error_count++;
            finish_run();
        end
    end

    initial begin
        frame_req_t req;
        frame_req_t req_b;
        payload_t   pay;
        payload_t   pay_b;
        i_rst_n   = 1'b0;
        i_start   = 1'b0;
        i_req     = '0;
        i_payload = '0;
        repeat (8) @(posedge clk);
        i_rst_n <= 1'b1;
        repeat (10) @(posedge clk);     // quiet before the first start

        random_request(PAY_DATA, 4'd8, req, pay);
        start_frame(req, pay, 1'b1);
        wait_drained();

        random_request(PAY_DATA, 4'd3, req, pay);   // short payload
        start_frame(req, pay, 1'b1);
        wait_drained();

        random_request(PAY_PATTERN, 4'd8, req, pay);
        start_frame(req, pay, 1'b1);
        wait_drained();

        // second strobe lands mid frame
        random_request(PAY_DATA, 4'd5, req, pay);
        random_request(PAY_PATTERN, 4'd2, req_b, pay_b);
        start_frame(req, pay, 1'b1);
        repeat (20) @(posedge clk);
        start_frame(req_b, pay_b, 1'b0);
        wait_drained();

        random_request(PAY_DATA, 4'd6, req, pay);
        random_request(PAY_DATA, 4'd13, req_b, pay_b);  // clamps to 8
        start_frame(req, pay, 1'b1);
        wait_source_last();
        start_frame(req_b, pay_b, 1'b1);
        wait_drained();

        finish_run();
    end

endmodule

// ==== mac_frame_gen_asserts.sv ====
module mac_frame_gen_asserts (
    input logic                      clk,
    input logic                      i_rst_n,
    input logic                      i_valid,
    input logic                      i_last,
    input mac_frame_pkg::src_state_e i_src_state,
    input logic                      i_in_frame
);
    timeunit 1ns;
    timeprecision 1ps;
    import mac_frame_pkg::*;

    int fail_count = 0;

    no_valid_in_reset: assert property (@(posedge clk) !i_rst_n |-> !i_valid)
        else begin
            $error("o_valid high while reset is asserted");
            fail_count++;
        end

    last_with_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_last |-> i_valid)
        else begin
            $error("o_last high without o_valid");
            fail_count++;
        end

    gap_after_last: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_last |=> !i_valid)
        else begin
            $error("o_valid in the cycle right after o_last");
            fail_count++;
        end

    // a preamble needs a busy source, later words a packer already inside the frame
    valid_only_in_frame: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_valid |-> (i_src_state != IDLE) || $past(i_in_frame))
        else begin
            $error("o_valid with the source idle and no frame in flight");
            fail_count++;
        end

endmodule

bind mac_frame_gen mac_frame_gen_asserts mac_frame_gen_asserts_inst (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_valid     (o_valid),
    .i_last      (o_last),
    .i_src_state (frame_byte_source_inst.state_q),
    .i_in_frame  (word_packer_inst.in_frame_q)
);

// ==== mac_frame_gen.sv ====
module mac_frame_gen (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_start,
    input  mac_frame_pkg::frame_req_t i_req,
    input  mac_frame_pkg::payload_t   i_payload,
    output logic                      o_valid,
    output logic [63:0]               o_word,
    output logic                      o_last
);
    import mac_frame_pkg::*;

    logic       src_valid;
    byte_beat_t src_beat;    // header, payload, pad
    logic       fcs_valid;
    byte_beat_t fcs_beat;    // same bytes plus fcs

    frame_byte_source frame_byte_source_inst (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_req        (i_req),
        .i_payload    (i_payload),
        .o_beat_valid (src_valid),
        .o_beat       (src_beat)
    );

    fcs_inserter fcs_inserter_inst (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_beat_valid (src_valid),
        .i_beat       (src_beat),
        .o_beat_valid (fcs_valid),
        .o_beat       (fcs_beat)
    );

    word_packer word_packer_inst (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_beat_valid (fcs_valid),
        .i_beat       (fcs_beat),
        .o_valid      (o_valid),
        .o_word       (o_word),
        .o_last       (o_last)
    );

endmodule

// ==== word_packer.sv ====
`include "mac_frame_params.svh"

module word_packer (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_beat_valid,
    input  mac_frame_pkg::byte_beat_t i_beat,
    output logic                      o_valid,
    output logic [63:0]               o_word,
    output logic                      o_last
);

    localparam int CNT_W = $clog2(`MAC_WORD_BYTES);

    logic             in_frame_q;
    logic [CNT_W-1:0] cnt_q;       // bytes already in the assembly register
    logic [63:0]      asm_q;
    logic [63:0]      asm_next;
    logic             word_done;

    // first byte ends up in the top eight bits
    assign asm_next  = {asm_q[55:0], i_beat.data};
    assign word_done = i_beat_valid && in_frame_q &&
                       (cnt_q == CNT_W'(`MAC_WORD_BYTES - 1));

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid    <= 1'b0;
            o_last     <= 1'b0;
            in_frame_q <= 1'b0;
            cnt_q      <= '0;
        end else begin
            o_valid <= 1'b0;
            o_last  <= 1'b0;
            if (i_beat_valid) begin
                cnt_q <= cnt_q + 1'b1;   // wraps back to 0 on a full word
                if (!in_frame_q) begin
                    in_frame_q <= 1'b1;
                    o_valid    <= 1'b1;    // preamble word
                end else if (word_done) begin
                    o_valid <= 1'b1;
                    o_last  <= i_beat.last;
                end
                if (i_beat.last) begin
                    in_frame_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_beat_valid) begin
            asm_q <= asm_next;
            if (!in_frame_q) begin
                o_word <= `MAC_PREAMBLE_SFD;
            end else if (word_done) begin
                o_word <= asm_next;
            end
        end
    end

endmodule

// ==== fcs_inserter.sv ====
`include "mac_frame_params.svh"

module fcs_inserter (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_beat_valid,
    input  mac_frame_pkg::byte_beat_t i_beat,
    output logic                      o_beat_valid,
    output mac_frame_pkg::byte_beat_t o_beat
);
    import mac_frame_pkg::*;

    localparam logic [1:0] LAST_FCS = 2'(`MAC_FCS_BYTES - 1);

    fcs_state_e  state_q;
    logic [31:0] crc_q;
    logic [1:0]  fcs_idx_q;   // which fcs byte goes out next
    logic [31:0] fcs;

    // one byte into the reflected crc lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc_in, input logic [7:0] d);
        logic [31:0] c;
        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ d[i]) begin
                c = (c >> 1) ^ `MAC_CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign fcs = ~crc_q;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q      <= PASS;
            crc_q        <= `MAC_CRC_INIT;
            fcs_idx_q    <= '0;
            o_beat_valid <= 1'b0;
            o_beat       <= '0;
        end else begin
            o_beat_valid <= 1'b0;
            o_beat.last  <= 1'b0;
            case (state_q)
                PASS: begin
                    if (i_beat_valid) begin
                        o_beat_valid <= 1'b1;
                        o_beat.data  <= i_beat.data;   // incoming last is dropped
                        crc_q        <= crc_byte(crc_q, i_beat.data);
                        if (i_beat.last) begin
                            state_q   <= FCS;
                            fcs_idx_q <= '0;
                        end
                    end
                end
                FCS: begin
                    // source holds its next frame off so no input arrives here
                    o_beat_valid <= 1'b1;
                    o_beat.data  <= fcs[{fcs_idx_q, 3'b000} +: 8];  // low byte first
                    o_beat.last  <= (fcs_idx_q == LAST_FCS);
                    fcs_idx_q    <= fcs_idx_q + 2'd1;
                    if (fcs_idx_q == LAST_FCS) begin
                        state_q <= PASS;
                        crc_q   <= `MAC_CRC_INIT;
                    end
                end
                default: state_q <= PASS;
            endcase
        end
    end

endmodule

// ==== frame_byte_source.sv ====
`include "mac_frame_params.svh"

module frame_byte_source (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_start,
    input  mac_frame_pkg::frame_req_t i_req,
    input  mac_frame_pkg::payload_t   i_payload,
    output logic                      o_beat_valid,
    output mac_frame_pkg::byte_beat_t o_beat
);
    import mac_frame_pkg::*;

    localparam int         FRAME_BYTES = `MAC_HEADER_BYTES + `MAC_MIN_PAYLOAD;  // fcs excluded
    localparam logic [5:0] HDR_END     = 6'(`MAC_HEADER_BYTES - 1);
    localparam logic [5:0] LAST_CNT    = 6'(FRAME_BYTES - 1);
    // fcs bytes plus one idle cycle between output frames
    localparam logic [2:0] GAP_CYCLES  = 3'(`MAC_FCS_BYTES + 1);

    src_state_e state_q;
    logic [5:0] cnt_q;      // byte index within the frame
    logic [2:0] hold_q;     // holds off the next frame until the fcs is out
    frame_req_t req_q;
    payload_t   payload_q;

    logic                               take_req;
    logic [3:0]                         len;
    logic [5:0]                         pay_end;
    logic [5:0]                         pay_off;
    logic [0:`MAC_HEADER_BYTES-1][7:0]  hdr_bytes;
    logic [7:0]                         pay_byte;
    logic                               beat_en;
    logic                               last_byte;

    assign take_req  = (state_q == IDLE) && i_start;
    assign len       = (req_q.length > 4'(`MAC_PAYLOAD_BYTES)) ?
                       4'(`MAC_PAYLOAD_BYTES) : req_q.length;
    assign pay_end   = HDR_END + 6'(len);                 // index of last payload byte
    assign pay_off   = cnt_q - 6'(`MAC_HEADER_BYTES);
    assign hdr_bytes = {req_q.dest, req_q.src, req_q.eth_type};  // element 0 goes first
    assign pay_byte  = (req_q.mode == PAY_PATTERN) ? `MAC_PATTERN_BYTE :
                       payload_q[pay_off[2:0]];
    assign beat_en   = (state_q != IDLE) && (hold_q == '0);
    assign last_byte = (state_q == PAD) && (cnt_q == LAST_CNT);

    always_comb begin
        o_beat_valid = beat_en;
        o_beat.last  = beat_en && last_byte;
        case (state_q)
            HEADER:  o_beat.data = hdr_bytes[cnt_q[3:0]];
            PAYLOAD: o_beat.data = pay_byte;
            default: o_beat.data = 8'h00;   // zero padding
        endcase
    end

    // request and payload stay fixed for the whole frame
    always_ff @(posedge clk) begin
        if (take_req) begin
            req_q     <= i_req;
            payload_q <= i_payload;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            hold_q  <= '0;
        end else begin
            if (hold_q != '0) begin
                hold_q <= hold_q - 3'd1;
            end
            case (state_q)
                IDLE: begin
                    if (take_req) begin
                        state_q <= HEADER;
                        cnt_q   <= '0;
                    end
                end
                HEADER: begin
                    if (beat_en) begin
                        cnt_q <= cnt_q + 6'd1;
                        if (cnt_q == HDR_END) begin
                            state_q <= (len == 4'd0) ? PAD : PAYLOAD;
                        end
                    end
                end
                PAYLOAD: begin
                    if (beat_en) begin
                        cnt_q <= cnt_q + 6'd1;
                        if (cnt_q == pay_end) begin
                            state_q <= PAD;
                        end
                    end
                end
                PAD: begin
                    if (beat_en) begin
                        cnt_q <= cnt_q + 6'd1;
                        if (last_byte) begin
                            state_q <= IDLE;      // new start accepted from here
                            hold_q  <= GAP_CYCLES;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

// ==== mac_frame_pkg.sv ====
package mac_frame_pkg;

    `include "mac_frame_params.svh"

    typedef logic [47:0] mac_addr_t;

    typedef enum logic {
        PAY_DATA    = 1'b0,   // input bytes go out
        PAY_PATTERN = 1'b1    // every payload byte is 55h
    } payload_mode_e;

    typedef struct packed {
        mac_addr_t     dest;
        mac_addr_t     src;
        logic [15:0]   eth_type;
        logic [3:0]    length;    // above 8 is clamped
        payload_mode_e mode;
    } frame_req_t;

    // byte 0 sits at index 0 and is sent first
    typedef logic [`MAC_PAYLOAD_BYTES-1:0][7:0] payload_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;   // final byte of the stream
    } byte_beat_t;

    typedef enum logic [1:0] {IDLE, HEADER, PAYLOAD, PAD} src_state_e;

    typedef enum logic {PASS, FCS} fcs_state_e;

endpackage

// ==== mac_frame_params.svh ====
`ifndef MAC_FRAME_PARAMS_SVH
`define MAC_FRAME_PARAMS_SVH

// frame geometry in bytes
`define MAC_PAYLOAD_BYTES 8     // payload bytes carried per request
`define MAC_HEADER_BYTES  14    // dest + src + ethertype
`define MAC_MIN_PAYLOAD   46    // payload + pad
`define MAC_FCS_BYTES     4
`define MAC_WORD_BYTES    8     // bytes per output word

// substitute byte in pattern mode
`define MAC_PATTERN_BYTE 8'h55

// seven preamble bytes then the sfd
`define MAC_PREAMBLE_SFD 64'h5555_5555_5555_55D5

// crc-32 in reflected form
`define MAC_CRC_POLY 32'hEDB8_8320
`define MAC_CRC_INIT 32'hFFFF_FFFF

`endif
